//--- logic/axi_slv_defs.svh
// ********************
// widths, queue and buffer depths and memory map
// addresses of the AXI slave port
// ********************
`ifndef AXI_SLV_DEFS_SVH
`define AXI_SLV_DEFS_SVH

// ********************
// bus widths
// ********************
`define AXI_ADDR_WIDTH    32
`define AXI_DATA_WIDTH    32
`define AXI_ALEN_WIDTH    8

// outstanding request queues
`define AXI_MAX_OUTSTD_WR 2
`define AXI_MAX_OUTSTD_RD 2

// virtual channels and receive depth per channel
`define N_VIRT_CHN        2
`define RX_BUFF_SLOTS     4

// ********************
// memory map
// ********************
// channel n buffer sits at base + n * stride
`define WR_BUFF_BASE      'h1000
`define RD_BUFF_BASE      'h2000
`define VC_BUFF_STRIDE    8

`endif

//--- logic/axi_slv_pkg.sv
// ********************
// shared types of the AXI slave port
// and the memory map decode function
// ********************
`include "axi_slv_defs.svh"

package axi_slv_pkg;

  typedef logic [$clog2(`N_VIRT_CHN)-1:0] vc_id_t;
  typedef logic [`AXI_DATA_WIDTH-1:0]     flit_data_t;

  typedef enum logic [1:0] {FIXED = 2'd0, INCR = 2'd1, WRAP = 2'd2} axi_burst_t;
  typedef enum logic [1:0] {OKAY = 2'd0, SLVERR = 2'd2} axi_resp_t;
  typedef enum logic [1:0] {NONE, NOC_WR_FIFOS, NOC_RD_FIFOS} mm_region_t;

  // decoded region plus channel
  typedef struct packed {
    mm_region_t region;
    vc_id_t     vc;
  } mm_dec_t;

  // outstanding request queue entry
  typedef struct packed {
    logic [15:0]                addr;
    logic [`AXI_ALEN_WIDTH-1:0] len;
    logic [1:0]                 size;
    logic                       error;
  } ot_req_t;

  // exact match against each channel buffer address
  // anything else falls to NONE on channel 0
  function automatic mm_dec_t decode_mm_addr(logic [15:0] addr);
    mm_dec_t dec;
    dec.region = NONE;
    dec.vc     = '0;
    for (int i = 0; i < `N_VIRT_CHN; i++) begin
      if (addr == 16'(`WR_BUFF_BASE + `VC_BUFF_STRIDE * i)) begin
        dec.region = NOC_WR_FIFOS;
        dec.vc     = vc_id_t'(i);
      end else if (addr == 16'(`RD_BUFF_BASE + `VC_BUFF_STRIDE * i)) begin
        dec.region = NOC_RD_FIFOS;
        dec.vc     = vc_id_t'(i);
      end
    end
    return dec;
  endfunction

endpackage

//--- logic/sync_fifo.sv
// ********************
// first-word-fall-through FIFO
// with a type parameter for the payload
// ********************
module sync_fifo import axi_slv_pkg::*; #(
  parameter int  SLOTS = 4,
  parameter type T     = flit_data_t
) (
  input  logic clk_axi,
  input  logic arst_axi,
  input  logic write_i,
  input  logic read_i,
  input  T     data_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);
  localparam int PTR_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam int CNT_W = $clog2(SLOTS + 1);

  T                 mem [SLOTS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] next_count;
  logic             do_write;
  logic             do_read;

  // writes when full and reads when empty are dropped
  assign do_write   = write_i && !full_o;
  assign do_read    = read_i && !empty_o;
  assign next_count = count + CNT_W'(do_write) - CNT_W'(do_read);

  // head always visible
  assign data_o = mem[rd_ptr];

  always_ff @(posedge clk_axi) begin
    if (do_write) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // pointers wrap at SLOTS, flags come from the next count
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      full_o  <= 1'b0;
      empty_o <= 1'b1;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count   <= next_count;
      full_o  <= (next_count == CNT_W'(SLOTS));
      empty_o <= (next_count == '0);
    end
  end

endmodule

//--- logic/axi_wr_path.sv
// ********************
// write path: AW queue, W beats forwarded
// to the packet generator, B response
// ********************
`include "axi_slv_defs.svh"

module axi_wr_path import axi_slv_pkg::*; (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  // AW
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`AXI_ADDR_WIDTH-1:0] awaddr_i,
  input  logic [`AXI_ALEN_WIDTH-1:0] awlen_i,
  input  logic [2:0]                 awsize_i,
  input  axi_burst_t                 awburst_i,
  // W
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  flit_data_t                 wdata_i,
  input  logic                       wlast_i,
  // B
  output logic                       bvalid_o,
  input  logic                       bready_i,
  output axi_resp_t                  bresp_o,
  // flits out to the packet generator
  output logic                       pkt_valid_o,
  output vc_id_t                     pkt_vc_o,
  output logic                       pkt_new_o,
  output logic                       pkt_last_o,
  output logic [`AXI_ALEN_WIDTH:0]   pkt_sz_o,
  output flit_data_t                 pkt_data_o,
  input  logic                       pkt_ready_i
);
  ot_req_t   ot_in;
  ot_req_t   ot_head;
  logic      ot_full;
  logic      ot_empty;
  logic      ot_push;
  logic      ot_pop;
  mm_dec_t   head_dec;
  logic      fwd_flit;
  logic      w_hs;
  logic      head_flit_q;
  logic      bvalid_q;
  axi_resp_t bresp_q;

  // ********************
  // AW request queue
  // ********************
  assign awready_o = !ot_full;
  assign ot_push   = awvalid_i && awready_o;

  // only INCR bursts are served, the rest are flagged
  always_comb begin
    ot_in.addr  = awaddr_i[15:0];
    ot_in.len   = awlen_i;
    ot_in.size  = awsize_i[1:0];
    ot_in.error = (awburst_i != INCR);
  end

  sync_fifo #(
    .SLOTS (`AXI_MAX_OUTSTD_WR),
    .T     (ot_req_t)
  ) u_aw_queue (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ot_push),
    .read_i   (ot_pop),
    .data_i   (ot_in),
    .data_o   (ot_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // ********************
  // W beats
  // ********************
  assign head_dec = decode_mm_addr(ot_head.addr);
  assign fwd_flit = !ot_empty && !ot_head.error && (head_dec.region == NOC_WR_FIFOS);

  // no beats while B is pending, flits also wait for the packet generator
  assign wready_o = !ot_empty && !bvalid_q && (fwd_flit ? pkt_ready_i : 1'b1);
  assign w_hs     = wvalid_i && wready_o;
  // queue pops on the last beat whatever the region
  assign ot_pop   = w_hs && wlast_i;

  // beats of other regions or flagged bursts are swallowed here
  assign pkt_valid_o = fwd_flit && !bvalid_q && wvalid_i;
  assign pkt_vc_o    = head_dec.vc;
  assign pkt_new_o   = head_flit_q;
  assign pkt_last_o  = wlast_i;
  assign pkt_sz_o    = (`AXI_ALEN_WIDTH+1)'(ot_head.len) + 1'b1;
  assign pkt_data_o  = wdata_i;

  // ********************
  // B response
  // ********************
  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

  always_ff @(posedge clk_axi) begin
    if (ot_pop) begin
      bresp_q <= ot_head.error ? SLVERR : OKAY;
    end
  end

  // head flag re-arms after each last beat
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      head_flit_q <= 1'b1;
      bvalid_q    <= 1'b0;
    end else begin
      if (w_hs) begin
        head_flit_q <= wlast_i;
      end
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end else if (ot_pop) begin
        bvalid_q <= 1'b1;
      end
    end
  end

endmodule

//--- logic/axi_rd_path.sv
// ********************
// read path: AR queue, beat counting,
// R beats and single-beat error responses
// ********************
`include "axi_slv_defs.svh"

module axi_rd_path import axi_slv_pkg::*; (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  // AR
  input  logic                       arvalid_i,
  output logic                       arready_o,
  input  logic [`AXI_ADDR_WIDTH-1:0] araddr_i,
  input  logic [`AXI_ALEN_WIDTH-1:0] arlen_i,
  input  logic [2:0]                 arsize_i,
  input  axi_burst_t                 arburst_i,
  // R
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output flit_data_t                 rdata_o,
  output axi_resp_t                  rresp_o,
  output logic                       rlast_o,
  // receive buffer port
  output vc_id_t                     rd_vc_o,
  output logic                       rd_pop_o,
  input  flit_data_t                 rd_data_i,
  input  logic                       rd_empty_i
);
  ot_req_t                    ot_in;
  ot_req_t                    ot_head;
  logic                       ot_full;
  logic                       ot_empty;
  logic                       ot_push;
  logic                       ot_pop;
  mm_dec_t                    head_dec;
  logic                       err_start;
  logic                       r_hs;
  logic                       txn_q;
  logic                       lock_q;
  logic [`AXI_ALEN_WIDTH-1:0] beat_q;

  // ********************
  // AR request queue
  // ********************
  assign arready_o = !ot_full;
  assign ot_push   = arvalid_i && arready_o;

  always_comb begin
    ot_in.addr  = araddr_i[15:0];
    ot_in.len   = arlen_i;
    ot_in.size  = arsize_i[1:0];
    ot_in.error = (arburst_i != INCR);
  end

  sync_fifo #(
    .SLOTS (`AXI_MAX_OUTSTD_RD),
    .T     (ot_req_t)
  ) u_ar_queue (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ot_push),
    .read_i   (ot_pop),
    .data_i   (ot_in),
    .data_o   (ot_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // ********************
  // R beats
  // ********************
  assign head_dec = decode_mm_addr(ot_head.addr);
  assign rd_vc_o  = head_dec.vc;

  // flagged burst, wrong region or nothing to read yet
  assign err_start = ot_head.error || (head_dec.region != NOC_RD_FIFOS) || rd_empty_i;

  always_comb begin
    rvalid_o = 1'b0;
    rlast_o  = 1'b0;
    rdata_o  = '0;
    rresp_o  = OKAY;
    if (txn_q) begin
      if (lock_q) begin
        // one beat, zero data
        rvalid_o = 1'b1;
        rlast_o  = 1'b1;
        rresp_o  = SLVERR;
      end else begin
        // buffer running dry mid-burst stalls rvalid
        rvalid_o = !rd_empty_i;
        rlast_o  = !rd_empty_i && (beat_q == ot_head.len);
        rdata_o  = rd_empty_i ? '0 : rd_data_i;
      end
    end
  end

  assign r_hs     = rvalid_o && rready_i;
  assign rd_pop_o = r_hs && !lock_q;
  assign ot_pop   = r_hs && rlast_o;

  // start one cycle after the head shows, lock latched at start
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      txn_q  <= 1'b0;
      lock_q <= 1'b0;
      beat_q <= '0;
    end else if (!txn_q) begin
      if (!ot_empty) begin
        txn_q  <= 1'b1;
        lock_q <= err_start;
        beat_q <= '0;
      end
    end else if (r_hs) begin
      beat_q <= beat_q + 1'b1;
      if (rlast_o) begin
        txn_q <= 1'b0;
      end
    end
  end

endmodule

//--- logic/rx_vc_buffers.sv
// ********************
// per-channel receive FIFOs, fed by the
// packet generator, read by the read path
// ********************
`include "axi_slv_defs.svh"

module rx_vc_buffers import axi_slv_pkg::*; (
  input  logic       clk_axi,
  input  logic       arst_axi,
  // inbound flits
  input  logic       rx_valid_i,
  input  vc_id_t     rx_vc_i,
  input  flit_data_t rx_data_i,
  output logic       rx_ready_o,
  // selected read port
  input  vc_id_t     rd_vc_i,
  input  logic       rd_pop_i,
  output flit_data_t rd_data_o,
  output logic       rd_empty_o
);
  logic [`N_VIRT_CHN-1:0] vc_full;
  logic [`N_VIRT_CHN-1:0] vc_empty;
  logic [`N_VIRT_CHN-1:0] vc_push;
  logic [`N_VIRT_CHN-1:0] vc_pop;
  flit_data_t             vc_head [`N_VIRT_CHN];

  // backpressure follows the addressed channel only
  assign rx_ready_o = !vc_full[rx_vc_i];

  // head and flag of the channel the read path points at
  assign rd_data_o  = vc_head[rd_vc_i];
  assign rd_empty_o = vc_empty[rd_vc_i];

  // ********************
  // one FIFO per channel
  // ********************
  for (genvar i = 0; i < `N_VIRT_CHN; i++) begin : g_vc
    // steer by channel id
    assign vc_push[i] = rx_valid_i && (rx_vc_i == vc_id_t'(i)) && !vc_full[i];
    assign vc_pop[i]  = rd_pop_i && (rd_vc_i == vc_id_t'(i));

    sync_fifo #(
      .SLOTS (`RX_BUFF_SLOTS),
      .T     (flit_data_t)
    ) u_vc_fifo (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .write_i  (vc_push[i]),
      .read_i   (vc_pop[i]),
      .data_i   (rx_data_i),
      .data_o   (vc_head[i]),
      .full_o   (vc_full[i]),
      .empty_o  (vc_empty[i])
    );
  end

endmodule

//--- logic/axi_slave_if.sv
// ********************
// AXI slave port top: write path, read path
// and receive buffers
// ********************
`include "axi_slv_defs.svh"

module axi_slave_if import axi_slv_pkg::*; (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  // AW
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`AXI_ADDR_WIDTH-1:0] awaddr_i,
  input  logic [`AXI_ALEN_WIDTH-1:0] awlen_i,
  input  logic [2:0]                 awsize_i,
  input  axi_burst_t                 awburst_i,
  // W
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  flit_data_t                 wdata_i,
  input  logic                       wlast_i,
  // B
  output logic                       bvalid_o,
  input  logic                       bready_i,
  output axi_resp_t                  bresp_o,
  // AR
  input  logic                       arvalid_i,
  output logic                       arready_o,
  input  logic [`AXI_ADDR_WIDTH-1:0] araddr_i,
  input  logic [`AXI_ALEN_WIDTH-1:0] arlen_i,
  input  logic [2:0]                 arsize_i,
  input  axi_burst_t                 arburst_i,
  // R
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output flit_data_t                 rdata_o,
  output axi_resp_t                  rresp_o,
  output logic                       rlast_o,
  // packet generator, outbound
  output logic                       pkt_valid_o,
  output vc_id_t                     pkt_vc_o,
  output logic                       pkt_new_o,
  output logic                       pkt_last_o,
  output logic [`AXI_ALEN_WIDTH:0]   pkt_sz_o,
  output flit_data_t                 pkt_data_o,
  input  logic                       pkt_ready_i,
  // packet generator, inbound
  input  logic                       rx_valid_i,
  input  vc_id_t                     rx_vc_i,
  input  flit_data_t                 rx_data_i,
  output logic                       rx_ready_o
);
  // read path to receive buffers
  vc_id_t     rd_vc;
  logic       rd_pop;
  flit_data_t rd_data;
  logic       rd_empty;

  axi_wr_path u_wr_path (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .awaddr_i    (awaddr_i),
    .awlen_i     (awlen_i),
    .awsize_i    (awsize_i),
    .awburst_i   (awburst_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .wdata_i     (wdata_i),
    .wlast_i     (wlast_i),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .bresp_o     (bresp_o),
    .pkt_valid_o (pkt_valid_o),
    .pkt_vc_o    (pkt_vc_o),
    .pkt_new_o   (pkt_new_o),
    .pkt_last_o  (pkt_last_o),
    .pkt_sz_o    (pkt_sz_o),
    .pkt_data_o  (pkt_data_o),
    .pkt_ready_i (pkt_ready_i)
  );

  axi_rd_path u_rd_path (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .araddr_i   (araddr_i),
    .arlen_i    (arlen_i),
    .arsize_i   (arsize_i),
    .arburst_i  (arburst_i),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rlast_o    (rlast_o),
    .rd_vc_o    (rd_vc),
    .rd_pop_o   (rd_pop),
    .rd_data_i  (rd_data),
    .rd_empty_i (rd_empty)
  );

  rx_vc_buffers u_rx_buffers (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .rx_valid_i (rx_valid_i),
    .rx_vc_i    (rx_vc_i),
    .rx_data_i  (rx_data_i),
    .rx_ready_o (rx_ready_o),
    .rd_vc_i    (rd_vc),
    .rd_pop_i   (rd_pop),
    .rd_data_o  (rd_data),
    .rd_empty_o (rd_empty)
  );

endmodule

//--- verif/axi_slave_chk.sv
// ********************
// concurrent protocol checks on the AXI slave
// port, bound into axi_slave_if
// ********************
module axi_slave_chk import axi_slv_pkg::*; (
  input logic       clk_axi,
  input logic       arst_axi,
  input logic       wvalid_i,
  input logic       bvalid_o,
  input logic       bready_i,
  input axi_resp_t  bresp_o,
  input logic       rvalid_o,
  input logic       rready_i,
  input flit_data_t rdata_o,
  input axi_resp_t  rresp_o,
  input logic       rlast_o,
  input logic       pkt_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // failures seen so far, polled by the testbench
  int err_cnt = 0;

  // ********************
  // response channels hold under backpressure
  // ********************
  a_b_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
  else begin
    err_cnt = err_cnt + 1;
    $error("B response changed or dropped before bready");
  end

  a_r_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o)
      && $stable(rlast_o))
  else begin
    err_cnt = err_cnt + 1;
    $error("R beat changed or dropped before rready");
  end

  // flits only ever come from a live W beat
  a_pkt_from_w: assert property (@(posedge clk_axi) disable iff (arst_axi)
    pkt_valid_o |-> wvalid_i)
  else begin
    err_cnt = err_cnt + 1;
    $error("pkt_valid_o high without wvalid");
  end

  // responses quiet right after reset release
  a_reset_quiet: assert property (@(posedge clk_axi)
    $fell(arst_axi) |-> !bvalid_o && !rvalid_o)
  else begin
    err_cnt = err_cnt + 1;
    $error("bvalid or rvalid high in the cycle after reset");
  end

endmodule

bind axi_slave_if axi_slave_chk u_chk (
  .clk_axi     (clk_axi),
  .arst_axi    (arst_axi),
  .wvalid_i    (wvalid_i),
  .bvalid_o    (bvalid_o),
  .bready_i    (bready_i),
  .bresp_o     (bresp_o),
  .rvalid_o    (rvalid_o),
  .rready_i    (rready_i),
  .rdata_o     (rdata_o),
  .rresp_o     (rresp_o),
  .rlast_o     (rlast_o),
  .pkt_valid_o (pkt_valid_o)
);

//--- verif/axi_slave_tb.sv
// ********************
// testbench of the AXI slave port: clock, reset,
// random stalls, AXI and rx stimulus tasks,
// flit and read-data model with assertions
// ********************
`include "axi_slv_defs.svh"

module axi_slave_tb import axi_slv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 200;

  logic                       clk_axi;
  logic                       arst_axi;
  logic                       awvalid_i;
  logic                       awready_o;
  logic [`AXI_ADDR_WIDTH-1:0] awaddr_i;
  logic [`AXI_ALEN_WIDTH-1:0] awlen_i;
  logic [2:0]                 awsize_i;
  axi_burst_t                 awburst_i;
  logic                       wvalid_i;
  logic                       wready_o;
  flit_data_t                 wdata_i;
  logic                       wlast_i;
  logic                       bvalid_o;
  logic                       bready_i;
  axi_resp_t                  bresp_o;
  logic                       arvalid_i;
  logic                       arready_o;
  logic [`AXI_ADDR_WIDTH-1:0] araddr_i;
  logic [`AXI_ALEN_WIDTH-1:0] arlen_i;
  logic [2:0]                 arsize_i;
  axi_burst_t                 arburst_i;
  logic                       rvalid_o;
  logic                       rready_i;
  flit_data_t                 rdata_o;
  axi_resp_t                  rresp_o;
  logic                       rlast_o;
  logic                       pkt_valid_o;
  vc_id_t                     pkt_vc_o;
  logic                       pkt_new_o;
  logic                       pkt_last_o;
  logic [`AXI_ALEN_WIDTH:0]   pkt_sz_o;
  flit_data_t                 pkt_data_o;
  logic                       pkt_ready_i;
  logic                       rx_valid_i;
  vc_id_t                     rx_vc_i;
  flit_data_t                 rx_data_i;
  logic                       rx_ready_o;

  integer seed = 32'he092;

  // model: W data sent, flits seen, read data expected
  logic [31:0]              wr_data  [$];
  logic [31:0]              got_data [$];
  vc_id_t                   got_vc   [$];
  logic                     got_new  [$];
  logic                     got_last [$];
  logic [`AXI_ALEN_WIDTH:0] got_sz   [$];
  logic [31:0]              rd_exp   [$];

  axi_slave_if UUT (.*);

  // 40 ns period
  initial clk_axi = 1'b0;
  always #20 clk_axi = ~clk_axi;

  // ********************
  // random backpressure, about one stall in four
  // ********************
  always @(negedge clk_axi) begin
    bready_i    = ($random(seed) % 4) != 0;
    rready_i    = ($random(seed) % 4) != 0;
    pkt_ready_i = ($random(seed) % 4) != 0;
  end

  // capture every accepted flit
  always @(posedge clk_axi) begin
    if (!arst_axi && pkt_valid_o && pkt_ready_i) begin
      got_data.push_back(pkt_data_o);
      got_vc.push_back(pkt_vc_o);
      got_new.push_back(pkt_new_o);
      got_last.push_back(pkt_last_o);
      got_sz.push_back(pkt_sz_o);
    end
  end

  // bound checker errors end the run at once
  always @(negedge clk_axi) begin
    if (UUT.u_chk.err_cnt != 0) begin
      $display("a protocol assertion in the bound checker failed");
      fail_stop();
    end
  end

  task automatic fail_stop();
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic timeout_stop(input string what);
    $display("timed out waiting for %s", what);
    fail_stop();
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    assert (act_v === exp_v)
    else begin
      $display("[FAIL] %s expected %h actual %h", name, exp_v, act_v);
      fail_stop();
    end
  endtask

  // ********************
  // stimulus tasks
  // ********************
  task automatic send_aw(input logic [31:0] addr, input logic [7:0] len,
                         input axi_burst_t burst);
    int n;
    @(negedge clk_axi);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    awlen_i   = len;
    awsize_i  = 3'd2;
    awburst_i = burst;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk_axi);
      if (awready_o) break;
    end
    if (n == WAIT_LIMIT) timeout_stop("an AW handshake");
    @(negedge clk_axi);
    awvalid_i = 1'b0;
  endtask

  task automatic send_ar(input logic [31:0] addr, input logic [7:0] len,
                         input axi_burst_t burst);
    int n;
    @(negedge clk_axi);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    arlen_i   = len;
    arsize_i  = 3'd2;
    arburst_i = burst;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk_axi);
      if (arready_o) break;
    end
    if (n == WAIT_LIMIT) timeout_stop("an AR handshake");
    @(negedge clk_axi);
    arvalid_i = 1'b0;
  endtask

  // W beats taken from wr_data, wvalid held across beats
  task automatic send_w(input int start, input int beats);
    int i;
    int n;
    for (i = 0; i < beats; i++) begin
      @(negedge clk_axi);
      wvalid_i = 1'b1;
      wdata_i  = wr_data[start + i];
      wlast_i  = (i == beats - 1);
      for (n = 0; n < WAIT_LIMIT; n++) begin
        @(posedge clk_axi);
        if (wready_o) break;
      end
      if (n == WAIT_LIMIT) timeout_stop("a W handshake");
    end
    @(negedge clk_axi);
    wvalid_i = 1'b0;
    wlast_i  = 1'b0;
  endtask

  task automatic wait_b(input string name, input axi_resp_t exp_resp);
    int n;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk_axi);
      if (bvalid_o && bready_i) break;
    end
    if (n == WAIT_LIMIT) timeout_stop("a B response");
    check_val(name, exp_resp, bresp_o);
  endtask

  task automatic push_rx(input vc_id_t vc, input logic [31:0] data);
    int n;
    @(negedge clk_axi);
    rx_valid_i = 1'b1;
    rx_vc_i    = vc;
    rx_data_i  = data;
    for (n = 0; n < WAIT_LIMIT; n++) begin
      @(posedge clk_axi);
      if (rx_ready_o) break;
    end
    if (n == WAIT_LIMIT) timeout_stop("rx_ready_o");
    @(negedge clk_axi);
    rx_valid_i = 1'b0;
  endtask

  // error bursts are one zero-data SLVERR beat
  task automatic read_burst(input string name, input int beats, input logic err);
    int i;
    int n;
    for (i = 0; i < beats; i++) begin
      for (n = 0; n < WAIT_LIMIT; n++) begin
        @(posedge clk_axi);
        if (rvalid_o && rready_i) break;
      end
      if (n == WAIT_LIMIT) timeout_stop("an R beat");
      if (err) begin
        check_val({name, " rresp"}, SLVERR, rresp_o);
        check_val({name, " rdata"}, 32'h0, rdata_o);
      end else begin
        check_val({name, " rdata"}, rd_exp.pop_front(), rdata_o);
        check_val({name, " rresp"}, OKAY, rresp_o);
      end
      check_val({name, " rlast"}, (i == beats - 1), rlast_o);
    end
  endtask

  // one packet: data in order, size = beats, new and last at the ends
  task automatic check_packet(input string name, input vc_id_t vc, input int got_at,
                              input int wr_at, input int beats);
    int i;
    for (i = 0; i < beats; i++) begin
      check_val({name, " data"}, wr_data[wr_at + i], got_data[got_at + i]);
      check_val({name, " vc"}, vc, got_vc[got_at + i]);
      check_val({name, " size"}, beats, got_sz[got_at + i]);
      check_val({name, " new"}, (i == 0), got_new[got_at + i]);
      check_val({name, " last"}, (i == beats - 1), got_last[got_at + i]);
    end
  endtask

  // ********************
  // test sequence
  // ********************
  initial begin
    int          i;
    logic [31:0] v;
    arst_axi    = 1'b1;
    awvalid_i   = 1'b0;
    awaddr_i    = '0;
    awlen_i     = '0;
    awsize_i    = '0;
    awburst_i   = INCR;
    wvalid_i    = 1'b0;
    wdata_i     = '0;
    wlast_i     = 1'b0;
    bready_i    = 1'b0;
    arvalid_i   = 1'b0;
    araddr_i    = '0;
    arlen_i     = '0;
    arsize_i    = '0;
    arburst_i   = INCR;
    rready_i    = 1'b0;
    pkt_ready_i = 1'b0;
    rx_valid_i  = 1'b0;
    rx_vc_i     = '0;
    rx_data_i   = '0;
    repeat (3) @(posedge clk_axi);
    @(negedge clk_axi);
    arst_axi = 1'b0;

    // INCR write of 4 beats to channel 1
    for (i = 0; i < 4; i++) begin
      wr_data.push_back($random(seed));
    end
    send_aw(`WR_BUFF_BASE + `VC_BUFF_STRIDE, 8'd3, INCR);
    send_w(0, 4);
    wait_b("incr write bresp", OKAY);
    check_val("incr write flit count", 4, got_data.size());
    check_packet("incr write", 1'b1, 0, 0, 4);

    // FIXED burst is drained without flits
    wr_data.push_back($random(seed));
    wr_data.push_back($random(seed));
    send_aw(`WR_BUFF_BASE, 8'd1, FIXED);
    send_w(4, 2);
    wait_b("fixed write bresp", SLVERR);
    check_val("fixed write flit count", 4, got_data.size());

    // rx flits on channel 0 read back in push order
    for (i = 0; i < 3; i++) begin
      v = $random(seed);
      rd_exp.push_back(v);
      push_rx(1'b0, v);
    end
    send_ar(`RD_BUFF_BASE, 8'd2, INCR);
    read_burst("vc0 read", 3, 1'b0);

    // empty channel and write-buffer address both give the error beat
    send_ar(`RD_BUFF_BASE + `VC_BUFF_STRIDE, 8'd3, INCR);
    read_burst("empty vc1 read", 1, 1'b1);
    send_ar(`WR_BUFF_BASE, 8'd0, INCR);
    read_burst("write address read", 1, 1'b1);

    // fill channel 1, backpressure only on that channel
    for (i = 0; i < `RX_BUFF_SLOTS; i++) begin
      v = $random(seed);
      rd_exp.push_back(v);
      push_rx(1'b1, v);
    end
    @(negedge clk_axi);
    rx_vc_i = 1'b1;
    @(posedge clk_axi);
    check_val("full vc1 rx_ready", 1'b0, rx_ready_o);
    @(negedge clk_axi);
    rx_vc_i = 1'b0;
    @(posedge clk_axi);
    check_val("free vc0 rx_ready", 1'b1, rx_ready_o);
    send_ar(`RD_BUFF_BASE + `VC_BUFF_STRIDE, `RX_BUFF_SLOTS - 1, INCR);
    read_burst("full vc1 read", `RX_BUFF_SLOTS, 1'b0);

    // two AW ahead of W data fill the write queue
    for (i = 0; i < 3; i++) begin
      wr_data.push_back($random(seed));
    end
    send_aw(`WR_BUFF_BASE, 8'd1, INCR);
    send_aw(`WR_BUFF_BASE + `VC_BUFF_STRIDE, 8'd0, INCR);
    @(posedge clk_axi);
    check_val("awready with full write queue", 1'b0, awready_o);
    send_w(6, 2);
    wait_b("first queued write bresp", OKAY);
    send_w(8, 1);
    wait_b("second queued write bresp", OKAY);
    check_val("queued write flit count", 7, got_data.size());
    check_packet("first queued write", 1'b0, 4, 6, 2);
    check_packet("second queued write", 1'b1, 6, 8, 1);

    repeat (4) @(posedge clk_axi);
    if (UUT.u_chk.err_cnt != 0) begin
      $display("protocol assertions failed in the bound checker");
      fail_stop();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- src.f
+incdir+logic
logic/axi_slv_pkg.sv
logic/sync_fifo.sv
logic/axi_wr_path.sv
logic/axi_rd_path.sv
logic/rx_vc_buffers.sv
logic/axi_slave_if.sv
verif/axi_slave_chk.sv
verif/axi_slave_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the AXI slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f src.f --top-module axi_slave_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running after a checker error so the testbench reports it
out=$(./obj_dir/Vaxi_slave_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
